/* design/tm_intf_pkg.sv */
package tm_intf_pkg;

	// Field widths
	localparam int PACKET_ID_W  = 6;
	localparam int QID_W        = 8;
	localparam int CONN_ID_W    = 10;
	localparam int PORT_W       = 4;
	localparam int BUF_PTR_W    = 12;
	localparam int PKT_LEN_W    = 14;
	localparam int READ_COUNT_W = 5;

	// Queued copy: drop, ucast, last, packet id, qid, buffer pointer, port, length
	localparam int COPY_W = 3 + PACKET_ID_W + QID_W + BUF_PTR_W + PORT_W + PKT_LEN_W;

	typedef logic [PACKET_ID_W-1:0]  packet_id_t;
	typedef logic [QID_W-1:0]        qid_t;
	typedef logic [CONN_ID_W-1:0]    conn_id_t;
	typedef logic [PORT_W-1:0]       port_t;
	typedef logic [BUF_PTR_W-1:0]    buf_ptr_t;
	typedef logic [PKT_LEN_W-1:0]    pkt_len_t;
	typedef logic [READ_COUNT_W-1:0] read_count_t;

	// Clearing sweep of the read-count RAM
	typedef enum logic [1:0] {
		INIT_IDLE,
		INIT_CLEAR,
		INIT_DONE
	} init_state_t;

endpackage

/* design/tm_intf_ifs.sv */
`timescale 1ns/1ps

// Polled copy, strobed together with poll_req
interface copy_if;
	logic                   valid;
	tm_intf_pkg::packet_id_t packet_id;
	tm_intf_pkg::qid_t       qid;
	logic                   ucast;
	logic                   last;
	logic                   drop;
	tm_intf_pkg::buf_ptr_t   buf_ptr;
	tm_intf_pkg::port_t      src_port;
	tm_intf_pkg::pkt_len_t   length;

	modport src (output valid, packet_id, qid, ucast, last, drop, buf_ptr, src_port, length);
	modport dst (input valid, packet_id, qid, ucast, last, drop, buf_ptr, src_port, length);
endinterface

// Read-count RAM access, read data one cycle after raddr
interface rc_ram_if;
	tm_intf_pkg::packet_id_t  raddr;
	tm_intf_pkg::read_count_t rdata;
	logic                    wr;
	tm_intf_pkg::packet_id_t  waddr;
	tm_intf_pkg::read_count_t wdata;
	logic                    init_done;

	modport user (output raddr, wr, waddr, wdata, input rdata, init_done);
	modport mem (input raddr, wr, waddr, wdata, output rdata, init_done);
endinterface

// Final-copy buffer release record
interface release_if;
	logic                    valid;
	tm_intf_pkg::read_count_t read_count;
	tm_intf_pkg::buf_ptr_t    buf_ptr;
	tm_intf_pkg::port_t       port;
	tm_intf_pkg::pkt_len_t    length;

	modport src (output valid, read_count, buf_ptr, port, length);
	modport dst (input valid, read_count, buf_ptr, port, length);
endinterface

/* design/sync_fifo.sv */
`timescale 1ns/1ps

module sync_fifo #(
	parameter int WIDTH      = 8,
	parameter int DEPTH_LOG2 = 4
) (
	input  logic                  clk,
	input  logic                  rst_n,
	input  logic                  wr,
	input  logic [WIDTH-1:0]      din,
	input  logic                  rd,
	output logic [WIDTH-1:0]      dout,
	output logic                  empty,
	output logic                  full,
	output logic [DEPTH_LOG2:0]   count
);

	localparam int DEPTH = 2 ** DEPTH_LOG2;

	logic [WIDTH-1:0]      mem [DEPTH];
	logic [DEPTH_LOG2-1:0] wptr;
	logic [DEPTH_LOG2-1:0] rptr;
	logic                  do_wr;
	logic                  do_rd;

	assign empty = (count == '0);
	assign full  = count[DEPTH_LOG2];
	assign dout  = mem[rptr];

	assign do_rd = rd & ~empty;
	// A full FIFO still takes a write when the head leaves in the same cycle
	assign do_wr = wr & (~full | do_rd);

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			wptr  <= '0;
			rptr  <= '0;
			count <= '0;
		end else begin
			wptr <= wptr + DEPTH_LOG2'(do_wr);
			rptr <= rptr + DEPTH_LOG2'(do_rd);
			if (do_wr && !do_rd)
				count <= count + 1'b1;
			else if (do_rd && !do_wr)
				count <= count - 1'b1;
		end
	end

	always_ff @(posedge clk) begin
		if (do_wr)
			mem[wptr] <= din;
	end

endmodule

/* design/rep_intake.sv */
`timescale 1ns/1ps

module rep_intake #(
	parameter int INTAKE_DEPTH_LOG2 = 4,
	parameter int BP_ON             = 10,
	parameter int BP_OFF            = 6
) (
	input  logic                    clk,
	input  logic                    rst_n,
	input  logic                    rep_enq_req,
	input  logic                    rep_enq_drop,
	input  logic                    rep_enq_ucast,
	input  logic                    rep_enq_last,
	input  tm_intf_pkg::packet_id_t rep_enq_packet_id,
	input  tm_intf_pkg::qid_t       rep_enq_qid,
	input  tm_intf_pkg::buf_ptr_t   rep_enq_buf_ptr,
	input  tm_intf_pkg::port_t      rep_enq_src_port,
	input  tm_intf_pkg::pkt_len_t   rep_enq_length,
	input  logic                    init_done,
	input  logic                    pend_full,
	output logic                    poll_req,
	output tm_intf_pkg::qid_t       poll_qid,
	output tm_intf_pkg::port_t      poll_src_port,
	output logic                    int_rep_bp,
	copy_if.src                     copy
);

	localparam logic [INTAKE_DEPTH_LOG2:0] BP_ON_CNT  = (INTAKE_DEPTH_LOG2+1)'(BP_ON);
	localparam logic [INTAKE_DEPTH_LOG2:0] BP_OFF_CNT = (INTAKE_DEPTH_LOG2+1)'(BP_OFF);

	logic                              req_d1;
	logic [tm_intf_pkg::COPY_W-1:0]    copy_d1;
	logic [tm_intf_pkg::COPY_W-1:0]    head;
	logic                              empty;
	logic [INTAKE_DEPTH_LOG2:0]        in_count;
	logic                              pop;

	logic                    h_drop;
	logic                    h_ucast;
	logic                    h_last;
	tm_intf_pkg::packet_id_t h_packet_id;
	tm_intf_pkg::qid_t       h_qid;
	tm_intf_pkg::buf_ptr_t   h_buf_ptr;
	tm_intf_pkg::port_t      h_src_port;
	tm_intf_pkg::pkt_len_t   h_length;

	////////////////////////////////////////
	// Intake queue

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n)
			req_d1 <= 1'b0;
		else
			req_d1 <= rep_enq_req;
	end

	always_ff @(posedge clk) begin
		copy_d1 <= {rep_enq_drop, rep_enq_ucast, rep_enq_last, rep_enq_packet_id,
			rep_enq_qid, rep_enq_buf_ptr, rep_enq_src_port, rep_enq_length};
	end

	sync_fifo #(
		.WIDTH      (tm_intf_pkg::COPY_W),
		.DEPTH_LOG2 (INTAKE_DEPTH_LOG2)
	) i_intake_fifo (
		.clk   (clk),
		.rst_n (rst_n),
		.wr    (req_d1),
		.din   (copy_d1),
		.rd    (pop),
		.dout  (head),
		.empty (empty),
		.full  (),
		.count (in_count)
	);

	assign {h_drop, h_ucast, h_last, h_packet_id, h_qid, h_buf_ptr, h_src_port,
		h_length} = head;

	////////////////////////////////////////
	// Poll issue and back-pressure

	// Hold polls until the counters are cleared and the pending queue has room
	assign pop = ~empty & init_done & ~pend_full;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			poll_req   <= 1'b0;
			copy.valid <= 1'b0;
			int_rep_bp <= 1'b0;
		end else begin
			poll_req   <= pop;
			copy.valid <= pop;
			if (in_count > BP_ON_CNT)
				int_rep_bp <= 1'b1;
			else if (in_count < BP_OFF_CNT)
				int_rep_bp <= 1'b0;
		end
	end

	always_ff @(posedge clk) begin
		poll_qid       <= h_qid;
		poll_src_port  <= h_src_port;
		copy.packet_id <= h_packet_id;
		copy.qid       <= h_qid;
		copy.ucast     <= h_ucast;
		copy.last      <= h_last;
		copy.drop      <= h_drop;
		copy.buf_ptr   <= h_buf_ptr;
		copy.src_port  <= h_src_port;
		copy.length    <= h_length;
	end

endmodule

/* design/read_count_ram.sv */
`timescale 1ns/1ps

module read_count_ram (
	input  logic clk,
	input  logic rst_n,
	rc_ram_if.mem ram
);

	localparam int ENTRIES = 2 ** tm_intf_pkg::PACKET_ID_W;

	tm_intf_pkg::read_count_t mem [ENTRIES];
	tm_intf_pkg::init_state_t state;
	tm_intf_pkg::init_state_t state_nxt;
	tm_intf_pkg::packet_id_t  init_addr;

	always_comb begin
		state_nxt = state;
		case (state)
			tm_intf_pkg::INIT_IDLE:  state_nxt = tm_intf_pkg::INIT_CLEAR;
			tm_intf_pkg::INIT_CLEAR: if (&init_addr) state_nxt = tm_intf_pkg::INIT_DONE;
			tm_intf_pkg::INIT_DONE:  state_nxt = tm_intf_pkg::INIT_DONE;
			default:                 state_nxt = tm_intf_pkg::INIT_IDLE;
		endcase
	end

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			state     <= tm_intf_pkg::INIT_IDLE;
			init_addr <= '0;
		end else begin
			state <= state_nxt;
			if (state == tm_intf_pkg::INIT_CLEAR)
				init_addr <= init_addr + 1'b1;
		end
	end

	assign ram.init_done = (state == tm_intf_pkg::INIT_DONE);

	// Sweep owns the write port until every entry is zero
	always_ff @(posedge clk) begin
		if (state == tm_intf_pkg::INIT_CLEAR)
			mem[init_addr] <= '0;
		else if (ram.wr)
			mem[ram.waddr] <= ram.wdata;
		ram.rdata <= mem[ram.raddr];
	end

endmodule

/* design/read_count_update.sv */
`timescale 1ns/1ps

module read_count_update #(
	parameter int PEND_DEPTH_LOG2 = 5
) (
	input  logic                    clk,
	input  logic                    rst_n,
	copy_if.dst                     copy,
	input  logic                    poll_ack,
	input  logic                    poll_drop,
	input  tm_intf_pkg::conn_id_t   poll_conn_id,
	output logic                    pend_full,
	rc_ram_if.user                  ram,
	output logic                    enq_req,
	output tm_intf_pkg::qid_t       enq_qid,
	output tm_intf_pkg::conn_id_t   enq_conn_id,
	output tm_intf_pkg::buf_ptr_t   enq_buf_ptr,
	release_if.src                  rel
);

	// Two polls can be in flight between the full check and the pending write
	localparam logic [PEND_DEPTH_LOG2:0] PEND_LIMIT =
		(PEND_DEPTH_LOG2+1)'(2 ** PEND_DEPTH_LOG2 - 2);

	logic [tm_intf_pkg::COPY_W-1:0] pend_head;
	logic [PEND_DEPTH_LOG2:0]       pend_count;

	logic                    p_drop;
	logic                    p_ucast;
	logic                    p_last;
	tm_intf_pkg::packet_id_t p_packet_id;
	tm_intf_pkg::qid_t       p_qid;
	tm_intf_pkg::buf_ptr_t   p_buf_ptr;
	tm_intf_pkg::port_t      p_src_port;
	tm_intf_pkg::pkt_len_t   p_length;

	logic                  ack_d1;
	logic                  drop_d1;
	tm_intf_pkg::conn_id_t conn_id_d1;

	logic                    s1_valid;
	logic                    s1_final;
	logic                    s1_drop;
	tm_intf_pkg::packet_id_t s1_packet_id;
	tm_intf_pkg::qid_t       s1_qid;
	tm_intf_pkg::conn_id_t   s1_conn_id;
	tm_intf_pkg::buf_ptr_t   s1_buf_ptr;
	tm_intf_pkg::port_t      s1_port;
	tm_intf_pkg::pkt_len_t   s1_length;

	tm_intf_pkg::read_count_t stored;
	tm_intf_pkg::read_count_t final_count;

	// Write-back history, index 0 is the write in progress
	logic                     wb_wr   [3];
	tm_intf_pkg::packet_id_t  wb_addr [3];
	tm_intf_pkg::read_count_t wb_data [3];

	////////////////////////////////////////
	// Pending copies, popped in ack order

	sync_fifo #(
		.WIDTH      (tm_intf_pkg::COPY_W),
		.DEPTH_LOG2 (PEND_DEPTH_LOG2)
	) i_pend_fifo (
		.clk   (clk),
		.rst_n (rst_n),
		.wr    (copy.valid),
		.din   ({copy.drop, copy.ucast, copy.last, copy.packet_id, copy.qid,
			copy.buf_ptr, copy.src_port, copy.length}),
		.rd    (ack_d1),
		.dout  (pend_head),
		.empty (),
		.full  (),
		.count (pend_count)
	);

	assign {p_drop, p_ucast, p_last, p_packet_id, p_qid, p_buf_ptr, p_src_port,
		p_length} = pend_head;

	assign pend_full = (pend_count >= PEND_LIMIT);
	assign ram.raddr = p_packet_id;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			ack_d1   <= 1'b0;
			s1_valid <= 1'b0;
			enq_req  <= 1'b0;
			rel.valid <= 1'b0;
			for (int i = 0; i < 3; i++)
				wb_wr[i] <= 1'b0;
		end else begin
			ack_d1   <= poll_ack;
			s1_valid <= ack_d1;
			enq_req  <= s1_valid & ~s1_drop;
			rel.valid <= s1_valid & s1_final;
			wb_wr[0] <= s1_valid;
			wb_wr[1] <= wb_wr[0];
			wb_wr[2] <= wb_wr[1];
		end
	end

	////////////////////////////////////////
	// Count update with forwarding

	// RAM data misses the last writes, so the youngest matching write wins
	always_comb begin
		stored = ram.rdata;
		for (int i = 2; i >= 0; i--) begin
			if (wb_wr[i] && wb_addr[i] == s1_packet_id)
				stored = wb_data[i];
		end
	end

	assign final_count = stored + tm_intf_pkg::read_count_t'(!s1_drop);

	assign ram.wr    = wb_wr[0];
	assign ram.waddr = wb_addr[0];
	assign ram.wdata = wb_data[0];

	always_ff @(posedge clk) begin
		drop_d1    <= poll_drop;
		conn_id_d1 <= poll_conn_id;

		s1_final     <= p_ucast | p_last;
		s1_drop      <= drop_d1 | p_drop;
		s1_packet_id <= p_packet_id;
		s1_qid       <= p_qid;
		s1_conn_id   <= conn_id_d1;
		s1_buf_ptr   <= p_buf_ptr;
		s1_port      <= p_src_port;
		s1_length    <= p_length;

		wb_addr[0] <= s1_packet_id;
		wb_data[0] <= s1_final ? '0 : final_count;
		wb_addr[1] <= wb_addr[0];
		wb_data[1] <= wb_data[0];
		wb_addr[2] <= wb_addr[1];
		wb_data[2] <= wb_data[1];

		enq_qid     <= s1_qid;
		enq_conn_id <= s1_conn_id;
		enq_buf_ptr <= s1_buf_ptr;

		rel.read_count <= final_count;
		rel.buf_ptr    <= s1_buf_ptr;
		rel.port       <= s1_port;
		rel.length     <= s1_length;
	end

endmodule

/* design/release_arbiter.sv */
`timescale 1ns/1ps

module release_arbiter #(
	parameter int REL_DEPTH_LOG2 = 5
) (
	input  logic                     clk,
	input  logic                     rst_n,
	release_if.dst                   rel,
	input  logic                     discard_req,
	input  tm_intf_pkg::buf_ptr_t    discard_buf_ptr,
	input  tm_intf_pkg::port_t       discard_port,
	input  tm_intf_pkg::pkt_len_t    discard_length,
	output logic                     rel_valid,
	output tm_intf_pkg::read_count_t rel_read_count,
	output tm_intf_pkg::buf_ptr_t    rel_buf_ptr,
	output tm_intf_pkg::port_t       rel_port,
	output tm_intf_pkg::pkt_len_t    rel_length
);

	localparam int REL_W = tm_intf_pkg::READ_COUNT_W + tm_intf_pkg::BUF_PTR_W +
		tm_intf_pkg::PORT_W + tm_intf_pkg::PKT_LEN_W;

	logic                     discard_d1;
	tm_intf_pkg::buf_ptr_t    discard_buf_ptr_d1;
	tm_intf_pkg::port_t       discard_port_d1;
	tm_intf_pkg::pkt_len_t    discard_length_d1;

	logic                     q_empty;
	logic                     q_rd;
	tm_intf_pkg::read_count_t q_read_count;
	tm_intf_pkg::buf_ptr_t    q_buf_ptr;
	tm_intf_pkg::port_t       q_port;
	tm_intf_pkg::pkt_len_t    q_length;

	sync_fifo #(
		.WIDTH      (REL_W),
		.DEPTH_LOG2 (REL_DEPTH_LOG2)
	) i_rel_fifo (
		.clk   (clk),
		.rst_n (rst_n),
		.wr    (rel.valid),
		.din   ({rel.read_count, rel.buf_ptr, rel.port, rel.length}),
		.rd    (q_rd),
		.dout  ({q_read_count, q_buf_ptr, q_port, q_length}),
		.empty (q_empty),
		.full  (),
		.count ()
	);

	// Discard takes the output slot, the queue waits
	assign q_rd = ~discard_d1 & ~q_empty;

	always_ff @(posedge clk or negedge rst_n) begin
		if (!rst_n) begin
			discard_d1 <= 1'b0;
			rel_valid  <= 1'b0;
		end else begin
			discard_d1 <= discard_req;
			rel_valid  <= discard_d1 | ~q_empty;
		end
	end

	always_ff @(posedge clk) begin
		discard_buf_ptr_d1 <= discard_buf_ptr;
		discard_port_d1    <= discard_port;
		discard_length_d1  <= discard_length;

		rel_read_count <= discard_d1 ? '0 : q_read_count;
		rel_buf_ptr    <= discard_d1 ? discard_buf_ptr_d1 : q_buf_ptr;
		rel_port       <= discard_d1 ? discard_port_d1 : q_port;
		rel_length     <= discard_d1 ? discard_length_d1 : q_length;
	end

endmodule

/* design/tm_intf_top.sv */
`timescale 1ns/1ps

module tm_intf_top #(
	parameter int INTAKE_DEPTH_LOG2 = 4,
	parameter int PEND_DEPTH_LOG2   = 5,
	parameter int REL_DEPTH_LOG2    = 5,
	parameter int BP_ON             = 10,
	parameter int BP_OFF            = 6
) (
	input  logic                     clk,
	input  logic                     rst_n,

	// Replicated copies
	input  logic                     rep_enq_req,
	input  logic                     rep_enq_drop,
	input  logic                     rep_enq_ucast,
	input  logic                     rep_enq_last,
	input  tm_intf_pkg::packet_id_t  rep_enq_packet_id,
	input  tm_intf_pkg::qid_t        rep_enq_qid,
	input  tm_intf_pkg::buf_ptr_t    rep_enq_buf_ptr,
	input  tm_intf_pkg::port_t       rep_enq_src_port,
	input  tm_intf_pkg::pkt_len_t    rep_enq_length,
	output logic                     int_rep_bp,

	// TM poll and enqueue
	output logic                     poll_req,
	output tm_intf_pkg::qid_t        poll_qid,
	output tm_intf_pkg::port_t       poll_src_port,
	input  logic                     poll_ack,
	input  logic                     poll_drop,
	input  tm_intf_pkg::conn_id_t    poll_conn_id,
	output logic                     enq_req,
	output tm_intf_pkg::qid_t        enq_qid,
	output tm_intf_pkg::conn_id_t    enq_conn_id,
	output tm_intf_pkg::buf_ptr_t    enq_buf_ptr,

	// Discard and buffer release
	input  logic                     discard_req,
	input  tm_intf_pkg::buf_ptr_t    discard_buf_ptr,
	input  tm_intf_pkg::port_t       discard_port,
	input  tm_intf_pkg::pkt_len_t    discard_length,
	output logic                     rel_valid,
	output tm_intf_pkg::read_count_t rel_read_count,
	output tm_intf_pkg::buf_ptr_t    rel_buf_ptr,
	output tm_intf_pkg::port_t       rel_port,
	output tm_intf_pkg::pkt_len_t    rel_length
);

	logic pend_full;

	copy_if    copy ();
	rc_ram_if  ram ();
	release_if rel ();

	rep_intake #(
		.INTAKE_DEPTH_LOG2 (INTAKE_DEPTH_LOG2),
		.BP_ON             (BP_ON),
		.BP_OFF            (BP_OFF)
	) i_rep_intake (
		.init_done (ram.init_done),
		.*
	);

	read_count_update #(
		.PEND_DEPTH_LOG2 (PEND_DEPTH_LOG2)
	) i_read_count_update (
		.*
	);

	read_count_ram i_read_count_ram (
		.*
	);

	release_arbiter #(
		.REL_DEPTH_LOG2 (REL_DEPTH_LOG2)
	) i_release_arbiter (
		.*
	);

endmodule

/* tests/tm_intf_tb.sv */
`timescale 1ns/1ps

module tm_intf_tb;

	localparam int SWEEP_CYCLES     = 65;
	localparam int FIRST_POLL_LIMIT = 80;
	localparam int BP_TIMEOUT       = 300;
	localparam int IDLE_TIMEOUT     = 2000;
	localparam int BP_ON_LEVEL      = 10;
	localparam int BP_OFF_LEVEL     = 6;

	typedef struct packed {
		tm_intf_pkg::packet_id_t packet_id;
		tm_intf_pkg::qid_t       qid;
		logic                    ucast;
		logic                    last;
		logic                    drop;
		tm_intf_pkg::buf_ptr_t   buf_ptr;
		tm_intf_pkg::port_t      src_port;
		tm_intf_pkg::pkt_len_t   length;
	} copy_t;

	typedef struct packed {
		tm_intf_pkg::qid_t     qid;
		tm_intf_pkg::conn_id_t conn_id;
		tm_intf_pkg::buf_ptr_t buf_ptr;
		int                    due;
	} enq_exp_t;

	// Discard releases have a fixed latency but copy releases do not
	typedef struct packed {
		tm_intf_pkg::read_count_t read_count;
		tm_intf_pkg::buf_ptr_t    buf_ptr;
		tm_intf_pkg::port_t       port;
		tm_intf_pkg::pkt_len_t    length;
		logic                     timed;
		int                       due;
	} rel_exp_t;

	logic                     clk;
	logic                     rst_n;
	logic                     rep_enq_req;
	logic                     rep_enq_drop;
	logic                     rep_enq_ucast;
	logic                     rep_enq_last;
	tm_intf_pkg::packet_id_t  rep_enq_packet_id;
	tm_intf_pkg::qid_t        rep_enq_qid;
	tm_intf_pkg::buf_ptr_t    rep_enq_buf_ptr;
	tm_intf_pkg::port_t       rep_enq_src_port;
	tm_intf_pkg::pkt_len_t    rep_enq_length;
	logic                     int_rep_bp;
	logic                     poll_req;
	tm_intf_pkg::qid_t        poll_qid;
	tm_intf_pkg::port_t       poll_src_port;
	logic                     poll_ack;
	logic                     poll_drop;
	tm_intf_pkg::conn_id_t    poll_conn_id;
	logic                     enq_req;
	tm_intf_pkg::qid_t        enq_qid;
	tm_intf_pkg::conn_id_t    enq_conn_id;
	tm_intf_pkg::buf_ptr_t    enq_buf_ptr;
	logic                     discard_req;
	tm_intf_pkg::buf_ptr_t    discard_buf_ptr;
	tm_intf_pkg::port_t       discard_port;
	tm_intf_pkg::pkt_len_t    discard_length;
	logic                     rel_valid;
	tm_intf_pkg::read_count_t rel_read_count;
	tm_intf_pkg::buf_ptr_t    rel_buf_ptr;
	tm_intf_pkg::port_t       rel_port;
	tm_intf_pkg::pkt_len_t    rel_length;

	int cyc = 0;
	int rst_cyc = 0;
	int polls_seen = 0;
	int copies_sent = 0;
	int ack_wait = -1;
	int intake_cnt = 0;
	logic req_d1 = 1'b0;
	logic req_d2 = 1'b0;
	logic bp_exp = 1'b0;
	logic tm_hold = 1'b0;
	logic tm_fast = 1'b0;
	logic bp_seen = 1'b0;

	copy_t    sent_q [$];
	copy_t    polled [$];
	enq_exp_t exp_enq [$];
	rel_exp_t exp_rel [$];
	tm_intf_pkg::read_count_t counts [64];

	tm_intf_top i_tm_intf_top (.*);

	always #5 clk = ~clk;

	always @(posedge clk) cyc <= cyc + 1;

	////////////////////////////////////////
	// Reporting and compares

	task automatic report_error(input string what);
		$display("%s", what);
		$display("Regression failed");
		$fatal(1, "stopping at first error");
	endtask

	task automatic check_low(input string name, input logic value);
		if (value !== 1'b0)
			report_error($sformatf("MISMATCH %s expected 0 got %h", name, value));
	endtask

	task automatic check_poll(input tm_intf_pkg::qid_t qid, input tm_intf_pkg::port_t port);
		if (poll_qid !== qid)
			report_error($sformatf("MISMATCH poll_qid expected %h got %h", qid, poll_qid));
		if (poll_src_port !== port)
			report_error($sformatf("MISMATCH poll_src_port expected %h got %h",
				port, poll_src_port));
	endtask

	task automatic check_enq(input tm_intf_pkg::qid_t qid, input tm_intf_pkg::conn_id_t conn_id,
			input tm_intf_pkg::buf_ptr_t buf_ptr);
		if (enq_qid !== qid)
			report_error($sformatf("MISMATCH enq_qid expected %h got %h", qid, enq_qid));
		if (enq_conn_id !== conn_id)
			report_error($sformatf("MISMATCH enq_conn_id expected %h got %h",
				conn_id, enq_conn_id));
		if (enq_buf_ptr !== buf_ptr)
			report_error($sformatf("MISMATCH enq_buf_ptr expected %h got %h",
				buf_ptr, enq_buf_ptr));
	endtask

	task automatic check_release(input tm_intf_pkg::read_count_t read_count,
			input tm_intf_pkg::buf_ptr_t buf_ptr, input tm_intf_pkg::port_t port,
			input tm_intf_pkg::pkt_len_t length);
		if (rel_read_count !== read_count)
			report_error($sformatf("MISMATCH rel_read_count expected %h got %h",
				read_count, rel_read_count));
		if (rel_buf_ptr !== buf_ptr)
			report_error($sformatf("MISMATCH rel_buf_ptr expected %h got %h",
				buf_ptr, rel_buf_ptr));
		if (rel_port !== port)
			report_error($sformatf("MISMATCH rel_port expected %h got %h", port, rel_port));
		if (rel_length !== length)
			report_error($sformatf("MISMATCH rel_length expected %h got %h", length, rel_length));
	endtask

	// Expected results of one acked copy in ack order
	function automatic void predict(input copy_t c, input logic tm_drop,
			input tm_intf_pkg::conn_id_t conn_id);
		enq_exp_t e;
		rel_exp_t r;
		logic     survives;
		survives = !c.drop && !tm_drop;
		if (survives) begin
			e.qid     = c.qid;
			e.conn_id = conn_id;
			e.buf_ptr = c.buf_ptr;
			e.due     = cyc + 3;
			exp_enq.push_back(e);
			counts[c.packet_id] = counts[c.packet_id] + tm_intf_pkg::read_count_t'(1);
		end
		if (c.ucast || c.last) begin
			r.read_count = counts[c.packet_id];
			r.buf_ptr    = c.buf_ptr;
			r.port       = c.src_port;
			r.length     = c.length;
			r.timed      = 1'b0;
			r.due        = 0;
			exp_rel.push_back(r);
			counts[c.packet_id] = '0;
		end
	endfunction

	////////////////////////////////////////
	// TM model and monitors

	always begin
		@(posedge clk);
		#1;
		poll_ack = 1'b0;
		if (!tm_hold && polled.size() > 0) begin
			if (ack_wait < 0)
				ack_wait = tm_fast ? 0 : int'($urandom_range(3, 0));
			if (ack_wait == 0) begin
				poll_ack     = 1'b1;
				poll_drop    = ($urandom_range(7, 0) == 0);
				poll_conn_id = tm_intf_pkg::conn_id_t'($urandom);
				predict(polled.pop_front(), poll_drop, poll_conn_id);
				ack_wait = -1;
			end else begin
				ack_wait--;
			end
		end
	end

	always @(negedge clk) begin : poll_monitor
		copy_t c;
		if (poll_req) begin
			if (polls_seen == 0 && cyc - rst_cyc <= SWEEP_CYCLES)
				report_error("poll_req rose before the clearing sweep finished");
			if (sent_q.size() == 0) begin
				report_error("poll_req with no copy outstanding");
			end else begin
				c = sent_q.pop_front();
				check_poll(c.qid, c.src_port);
				polled.push_back(c);
				polls_seen++;
			end
		end
	end

	// Intake occupancy: a copy lands two edges after its strobe and each poll is one pop
	always @(negedge clk) begin : bp_monitor
		if (int_rep_bp !== bp_exp)
			report_error($sformatf("MISMATCH int_rep_bp expected %h got %h",
				bp_exp, int_rep_bp));
		intake_cnt = intake_cnt + int'(req_d2) - int'(poll_req);
		req_d2 = req_d1;
		req_d1 = rep_enq_req;
		if (intake_cnt > BP_ON_LEVEL)
			bp_exp = 1'b1;
		else if (intake_cnt < BP_OFF_LEVEL)
			bp_exp = 1'b0;
	end

	always @(negedge clk) begin : enq_monitor
		enq_exp_t e;
		if (enq_req) begin
			if (exp_enq.size() == 0) begin
				report_error("enq_req with no enqueue expected");
			end else begin
				e = exp_enq.pop_front();
				if (e.due != cyc)
					report_error($sformatf("enqueue at cycle %0d, expected at cycle %0d",
						cyc, e.due));
				check_enq(e.qid, e.conn_id, e.buf_ptr);
			end
		end else if (exp_enq.size() > 0 && exp_enq[0].due <= cyc) begin
			report_error("an expected enqueue did not appear");
		end
	end

	always @(negedge clk) begin : rel_monitor
		rel_exp_t r;
		if (rel_valid) begin
			if (exp_rel.size() == 0) begin
				report_error("rel_valid with no release expected");
			end else begin
				r = exp_rel.pop_front();
				if (r.timed && r.due != cyc)
					report_error($sformatf("discard release at cycle %0d, expected at cycle %0d",
						cyc, r.due));
				check_release(r.read_count, r.buf_ptr, r.port, r.length);
			end
		end else if (exp_rel.size() > 0 && exp_rel[0].timed && exp_rel[0].due <= cyc) begin
			report_error("a discard release did not appear");
		end
	end

	////////////////////////////////////////
	// Stimulus

	task automatic idle_cycles(input int n);
		repeat (n) begin
			@(posedge clk);
			#1;
		end
	endtask

	// Pauses on back-pressure and lets the TM drain meanwhile
	task automatic send_copy(input copy_t c);
		int waited;
		waited = 0;
		while (int_rep_bp) begin
			bp_seen = 1'b1;
			tm_hold = 1'b0;
			if (waited == BP_TIMEOUT)
				report_error("int_rep_bp did not fall after acks resumed");
			waited++;
			idle_cycles(1);
		end
		rep_enq_req       = 1'b1;
		rep_enq_drop      = c.drop;
		rep_enq_ucast     = c.ucast;
		rep_enq_last      = c.last;
		rep_enq_packet_id = c.packet_id;
		rep_enq_qid       = c.qid;
		rep_enq_buf_ptr   = c.buf_ptr;
		rep_enq_src_port  = c.src_port;
		rep_enq_length    = c.length;
		sent_q.push_back(c);
		copies_sent++;
		idle_cycles(1);
		rep_enq_req = 1'b0;
	endtask

	task automatic send_packet(input int pid_max, input int gap_max);
		int    n;
		copy_t c;
		n           = $urandom_range(6, 1);
		c.packet_id = tm_intf_pkg::packet_id_t'($urandom_range(pid_max, 0));
		c.buf_ptr   = tm_intf_pkg::buf_ptr_t'($urandom);
		c.src_port  = tm_intf_pkg::port_t'($urandom);
		c.length    = tm_intf_pkg::pkt_len_t'($urandom);
		for (int i = 0; i < n; i++) begin
			c.qid   = tm_intf_pkg::qid_t'($urandom);
			c.ucast = (n == 1);
			c.last  = (n > 1) && (i == n - 1);
			c.drop  = ($urandom_range(7, 0) == 0);
			send_copy(c);
			idle_cycles($urandom_range(gap_max, 0));
		end
	endtask

	task automatic send_discard();
		rel_exp_t r;
		r.read_count    = '0;
		r.buf_ptr       = tm_intf_pkg::buf_ptr_t'($urandom);
		r.port          = tm_intf_pkg::port_t'($urandom);
		r.length        = tm_intf_pkg::pkt_len_t'($urandom);
		r.timed         = 1'b1;
		r.due           = cyc + 2;
		discard_req     = 1'b1;
		discard_buf_ptr = r.buf_ptr;
		discard_port    = r.port;
		discard_length  = r.length;
		exp_rel.push_back(r);
		idle_cycles(1);
		discard_req = 1'b0;
	endtask

	task automatic wait_idle();
		int waited;
		waited = 0;
		while (sent_q.size() > 0 || polled.size() > 0 || exp_enq.size() > 0 ||
				exp_rel.size() > 0) begin
			if (waited == IDLE_TIMEOUT)
				report_error("timeout waiting for outstanding copies to drain");
			waited++;
			idle_cycles(1);
		end
	endtask

	initial begin
		void'($urandom(32'h840b84bf));
		clk               = 1'b0;
		rst_n             = 1'b0;
		rep_enq_req       = 1'b0;
		rep_enq_drop      = 1'b0;
		rep_enq_ucast     = 1'b0;
		rep_enq_last      = 1'b0;
		rep_enq_packet_id = '0;
		rep_enq_qid       = '0;
		rep_enq_buf_ptr   = '0;
		rep_enq_src_port  = '0;
		rep_enq_length    = '0;
		poll_ack          = 1'b0;
		poll_drop         = 1'b0;
		poll_conn_id      = '0;
		discard_req       = 1'b0;
		discard_buf_ptr   = '0;
		discard_port      = '0;
		discard_length    = '0;
		foreach (counts[i])
			counts[i] = '0;

		idle_cycles(16);
		check_low("int_rep_bp", int_rep_bp);
		check_low("poll_req", poll_req);
		check_low("enq_req", enq_req);
		check_low("rel_valid", rel_valid);
		rst_n   = 1'b1;
		rst_cyc = cyc;

		// First copy waits in the intake until the sweep is over
		send_packet(63, 0);
		while (polls_seen == 0) begin
			if (cyc - rst_cyc > FIRST_POLL_LIMIT)
				report_error("no poll within 80 cycles of reset");
			idle_cycles(1);
		end

		repeat (30)
			send_packet(63, 3);
		wait_idle();

		// Few packet ids and immediate acks exercise count forwarding
		tm_fast = 1'b1;
		repeat (30)
			send_packet(3, 0);
		wait_idle();
		tm_fast = 1'b0;

		repeat (12) begin
			send_discard();
			idle_cycles($urandom_range(2, 0));
		end
		wait_idle();

		////////////////////////////////////////
		// Burst against a stalled TM

		tm_hold = 1'b1;
		begin : burst
			int target;
			target = copies_sent + 64;
			while (copies_sent < target)
				send_packet(63, 0);
		end
		tm_hold = 1'b0;
		wait_idle();
		if (!bp_seen)
			report_error("int_rep_bp never rose during the burst");

		idle_cycles(10);
		$display("Regression passed");
		$finish;
	end

endmodule

/* tm_intf_top.f */
design/tm_intf_pkg.sv
design/tm_intf_ifs.sv
design/sync_fifo.sv
design/rep_intake.sv
design/read_count_ram.sv
design/read_count_update.sv
design/release_arbiter.sv
design/tm_intf_top.sv
tests/tm_intf_tb.sv

/* Makefile */
SIM      = verilator
FLAGS    = --binary --timing -Wno-fatal
TOP      = tm_intf_tb
FILELIST = tm_intf_top.f
OBJ_DIR  = obj_dir

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build and run the testbench"
	@echo "  clean  remove the build directory"

test:
	$(SIM) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	./$(OBJ_DIR)/V$(TOP)

clean:
	rm -rf $(OBJ_DIR)
